/* design/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 16;
    localparam int DEV_COUNT = 4;
    localparam int DEV_IDX_W = 2;

    // 4 KB per slot, slot index just above the offset
    localparam int OFFSET_W  = 12;
    localparam int RSVD_W    = ADDR_W - DEV_IDX_W - OFFSET_W;
    localparam int REG_COUNT = 4;  // word registers per peripheral

    localparam logic [DEV_IDX_W-1:0] EMPTY_SLOT = 2'd3;

    // abort limit for the access phase
    localparam int TIMEOUT_CYCLES = 16;
    localparam int TIMER_W        = 5;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [RSVD_W-1:0]    rsvd;
        logic [DEV_IDX_W-1:0] dev_idx;
        logic [OFFSET_W-1:0]  offset;   // reg_idx sits in offset[3:2]
    } apb_addr_f_t;

    typedef union packed {
        logic [ADDR_W-1:0] word;
        apb_addr_f_t       f;
    } apb_addr_u;

    typedef struct packed {
        apb_addr_u         addr;
        logic [DATA_W-1:0] wdata;
        logic              write;
    } apb_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              slverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* design/apb_wait_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_wait_timer (
    input  logic S_AXI_ACLK,
    input  logic S_AXI_ARESETN,
    input  logic timer_clear,
    input  logic timer_run,
    output logic timer_expired
);

    logic [bridge_pkg::TIMER_W-1:0] count;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN)
            count <= '0;
        else if (timer_clear)
            count <= '0;
        else if (timer_run && count != bridge_pkg::TIMER_W'(bridge_pkg::TIMEOUT_CYCLES))
            count <= count + 1'b1;   // saturates
    end

    // count is one behind the access cycle number
    assign timer_expired = timer_run &&
                           (count >= bridge_pkg::TIMER_W'(bridge_pkg::TIMEOUT_CYCLES - 1));

endmodule

`default_nettype wire

/* design/apb_dev_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_dev_decode (
    input  logic                             psel_en,
    input  bridge_pkg::apb_addr_u            paddr,
    input  logic                             penable,
    input  logic [bridge_pkg::DATA_W-1:0]    prdata [bridge_pkg::DEV_COUNT],
    input  logic [bridge_pkg::DEV_COUNT-1:0] pready,
    input  logic [bridge_pkg::DEV_COUNT-1:0] pslverr,
    output logic [bridge_pkg::DEV_COUNT-1:0] psel,
    output logic [bridge_pkg::DATA_W-1:0]    prdata_sel,
    output logic                             pready_sel,
    output logic                             pslverr_sel
);

    logic [bridge_pkg::DEV_IDX_W-1:0] idx;

    assign idx = paddr.f.dev_idx;

    always_comb begin
        psel      = '0;
        psel[idx] = psel_en;
        if (idx == bridge_pkg::EMPTY_SLOT) begin
            // nobody home, finish at once with an error
            prdata_sel  = '0;
            pready_sel  = penable;
            pslverr_sel = penable;
        end else begin
            prdata_sel  = prdata[idx];
            pready_sel  = pready[idx];
            pslverr_sel = pslverr[idx];
        end
    end

endmodule

`default_nettype wire

/* design/apb_reg_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_reg_slave #(
    parameter int WAIT_CYCLES = 0
) (
    input  logic                          S_AXI_ACLK,
    input  logic                          S_AXI_ARESETN,
    input  logic                          psel,
    input  logic                          penable,
    input  bridge_pkg::apb_addr_u         paddr,
    input  logic                          pwrite,
    input  logic [bridge_pkg::DATA_W-1:0] pwdata,
    output logic [bridge_pkg::DATA_W-1:0] prdata,
    output logic                          pready
);

    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    logic [CNT_W-1:0]              wait_cnt;
    logic [1:0]                    reg_idx;
    logic [bridge_pkg::DATA_W-1:0] regs [bridge_pkg::REG_COUNT];

    assign reg_idx = paddr.f.offset[3:2];
    assign pready  = psel && penable && (wait_cnt == CNT_W'(WAIT_CYCLES));
    assign prdata  = regs[reg_idx];

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN)
            wait_cnt <= '0;
        else if (!psel)
            wait_cnt <= '0;
        else if (penable && !pready)
            wait_cnt <= wait_cnt + 1'b1;
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            for (int i = 0; i < bridge_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end else if (psel && penable && pready && pwrite) begin
            regs[reg_idx] <= pwdata;   // only on the completing cycle
        end
    end

endmodule

`default_nettype wire

/* design/apb_seq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_seq_fsm (
    input  logic                          S_AXI_ACLK,
    input  logic                          S_AXI_ARESETN,
    input  logic                          xfer_req,
    input  bridge_pkg::apb_cmd_t          xfer_cmd,
    input  logic [bridge_pkg::DATA_W-1:0] prdata_sel,
    input  logic                          pready_sel,
    input  logic                          pslverr_sel,
    input  logic                          timer_expired,
    output logic                          xfer_ack,
    output bridge_pkg::apb_rsp_t          xfer_rsp,
    output logic                          psel_en,
    output logic                          penable,
    output bridge_pkg::apb_addr_u         paddr,
    output logic                          pwrite,
    output logic [bridge_pkg::DATA_W-1:0] pwdata,
    output logic                          timer_clear,
    output logic                          timer_run
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access,
        st_done
    } state_t;

    state_t state;
    logic   access_end;

    assign access_end  = pready_sel || timer_expired;
    assign timer_clear = (state == st_setup);
    assign timer_run   = (state == st_access);

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            state    <= st_idle;
            psel_en  <= 1'b0;
            penable  <= 1'b0;
            xfer_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (xfer_req) begin
                        state   <= st_setup;
                        psel_en <= 1'b1;
                    end
                end
                st_setup: begin
                    state   <= st_access;
                    penable <= 1'b1;
                end
                st_access: begin
                    if (access_end) begin
                        state    <= st_done;
                        psel_en  <= 1'b0;
                        penable  <= 1'b0;
                        xfer_ack <= 1'b1;
                    end
                end
                default: begin
                    // wait for the front end to let go
                    if (!xfer_req) begin
                        state    <= st_idle;
                        xfer_ack <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (state == st_idle && xfer_req) begin
            paddr  <= xfer_cmd.addr;
            pwrite <= xfer_cmd.write;
            pwdata <= xfer_cmd.wdata;
        end
        if (state == st_access && access_end) begin
            // a completed access beats a timeout in the same cycle
            xfer_rsp.rdata  <= pready_sel ? prdata_sel : '0;
            xfer_rsp.slverr <= pready_sel ? pslverr_sel : 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/axi_lite_front.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_front (
    input  logic                             S_AXI_ACLK,
    input  logic                             S_AXI_ARESETN,
    input  logic [bridge_pkg::ADDR_W-1:0]    S_AXI_AWADDR,
    input  logic [2:0]                       S_AXI_AWPROT,   // ignored
    input  logic                             S_AXI_AWVALID,
    output logic                             S_AXI_AWREADY,
    input  logic [bridge_pkg::DATA_W-1:0]    S_AXI_WDATA,
    input  logic [bridge_pkg::DATA_W/8-1:0]  S_AXI_WSTRB,    // whole words only
    input  logic                             S_AXI_WVALID,
    output logic                             S_AXI_WREADY,
    output logic [1:0]                       S_AXI_BRESP,
    output logic                             S_AXI_BVALID,
    input  logic                             S_AXI_BREADY,
    input  logic [bridge_pkg::ADDR_W-1:0]    S_AXI_ARADDR,
    input  logic [2:0]                       S_AXI_ARPROT,   // ignored
    input  logic                             S_AXI_ARVALID,
    output logic                             S_AXI_ARREADY,
    output logic [bridge_pkg::DATA_W-1:0]    S_AXI_RDATA,
    output logic [1:0]                       S_AXI_RRESP,
    output logic                             S_AXI_RVALID,
    input  logic                             S_AXI_RREADY,
    input  logic                             xfer_ack,
    input  bridge_pkg::apb_rsp_t             xfer_rsp,
    output logic                             xfer_req,
    output bridge_pkg::apb_cmd_t             xfer_cmd
);

    typedef enum logic [1:0] {
        ph_capture,
        ph_req,
        ph_resp
    } phase_t;

    // which channels hold a captured beat
    typedef struct packed {
        logic aw;
        logic w;
        logic ar;
    } chan_t;

    phase_t                        phase;
    chan_t                         chan;
    chan_t                         chan_n;
    logic                          is_write;
    logic                          aw_hs;
    logic                          w_hs;
    logic                          ar_hs;
    logic                          resp_hs;
    logic                          rd_only;
    logic                          start_wr;
    logic                          start_rd;
    logic                          cap_n;
    bridge_pkg::apb_addr_u         aw_addr;
    bridge_pkg::apb_addr_u         ar_addr;
    logic [bridge_pkg::DATA_W-1:0] wdata_q;
    logic [1:0]                    resp_q;

    assign aw_hs   = S_AXI_AWVALID && S_AXI_AWREADY;
    assign w_hs    = S_AXI_WVALID && S_AXI_WREADY;
    assign ar_hs   = S_AXI_ARVALID && S_AXI_ARREADY;
    assign resp_hs = (S_AXI_BVALID && S_AXI_BREADY) || (S_AXI_RVALID && S_AXI_RREADY);

    always_comb begin
        chan_n.aw = chan.aw | aw_hs;
        chan_n.w  = chan.w | w_hs;
        chan_n.ar = chan.ar | ar_hs;
        rd_only   = chan_n.ar && !chan_n.aw && !chan_n.w;
        // write wins, a read captured beside it waits
        start_wr  = (phase == ph_capture) && !xfer_ack && chan_n.aw && chan_n.w;
        start_rd  = (phase == ph_capture) && !xfer_ack && rd_only;
        if (start_wr) begin
            chan_n.aw = 1'b0;
            chan_n.w  = 1'b0;
        end
        if (start_rd)
            chan_n.ar = 1'b0;
        cap_n = ((phase == ph_capture) && !start_wr && !start_rd) ||
                ((phase == ph_resp) && resp_hs);
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            phase         <= ph_capture;
            chan          <= '0;
            is_write      <= 1'b0;
            xfer_req      <= 1'b0;
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
            S_AXI_ARREADY <= 1'b0;
            S_AXI_BVALID  <= 1'b0;
            S_AXI_RVALID  <= 1'b0;
        end else begin
            chan          <= chan_n;
            S_AXI_AWREADY <= cap_n && !chan_n.aw && !rd_only;
            S_AXI_WREADY  <= cap_n && !chan_n.w && !rd_only;
            S_AXI_ARREADY <= cap_n && !chan_n.ar && !chan_n.aw && !chan_n.w;
            case (phase)
                ph_capture: begin
                    if (start_wr || start_rd) begin
                        phase    <= ph_req;
                        xfer_req <= 1'b1;
                        is_write <= start_wr;
                    end
                end
                ph_req: begin
                    if (xfer_ack) begin
                        phase        <= ph_resp;
                        xfer_req     <= 1'b0;
                        S_AXI_BVALID <= is_write;
                        S_AXI_RVALID <= !is_write;
                    end
                end
                default: begin
                    if (resp_hs) begin
                        phase        <= ph_capture;
                        S_AXI_BVALID <= 1'b0;
                        S_AXI_RVALID <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs)
            aw_addr.word <= S_AXI_AWADDR;
        if (w_hs)
            wdata_q <= S_AXI_WDATA;
        if (ar_hs)
            ar_addr.word <= S_AXI_ARADDR;
        if (phase == ph_req && xfer_ack) begin
            resp_q      <= xfer_rsp.slverr ? bridge_pkg::RESP_SLVERR : bridge_pkg::RESP_OKAY;
            S_AXI_RDATA <= xfer_rsp.rdata;
        end
    end

    always_comb begin
        xfer_cmd.addr  = is_write ? aw_addr : ar_addr;
        xfer_cmd.wdata = wdata_q;
        xfer_cmd.write = is_write;
    end

    assign S_AXI_BRESP = resp_q;
    assign S_AXI_RRESP = resp_q;

endmodule

`default_nettype wire

/* design/apb_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_subsys_top (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETN,
    input  logic [bridge_pkg::ADDR_W-1:0]   S_AXI_AWADDR,
    input  logic [2:0]                      S_AXI_AWPROT,
    input  logic                            S_AXI_AWVALID,
    output logic                            S_AXI_AWREADY,
    input  logic [bridge_pkg::DATA_W-1:0]   S_AXI_WDATA,
    input  logic [bridge_pkg::DATA_W/8-1:0] S_AXI_WSTRB,
    input  logic                            S_AXI_WVALID,
    output logic                            S_AXI_WREADY,
    output logic [1:0]                      S_AXI_BRESP,
    output logic                            S_AXI_BVALID,
    input  logic                            S_AXI_BREADY,
    input  logic [bridge_pkg::ADDR_W-1:0]   S_AXI_ARADDR,
    input  logic [2:0]                      S_AXI_ARPROT,
    input  logic                            S_AXI_ARVALID,
    output logic                            S_AXI_ARREADY,
    output logic [bridge_pkg::DATA_W-1:0]   S_AXI_RDATA,
    output logic [1:0]                      S_AXI_RRESP,
    output logic                            S_AXI_RVALID,
    input  logic                            S_AXI_RREADY
);

    logic                             xfer_req;
    logic                             xfer_ack;
    bridge_pkg::apb_cmd_t             xfer_cmd;
    bridge_pkg::apb_rsp_t             xfer_rsp;
    logic                             psel_en;
    logic                             penable;
    bridge_pkg::apb_addr_u            paddr;
    logic                             pwrite;
    logic [bridge_pkg::DATA_W-1:0]    pwdata;
    logic [bridge_pkg::DEV_COUNT-1:0] psel;
    logic [bridge_pkg::DEV_COUNT-1:0] pready;
    logic [bridge_pkg::DATA_W-1:0]    prdata [bridge_pkg::DEV_COUNT];
    logic [bridge_pkg::DATA_W-1:0]    prdata_sel;
    logic                             pready_sel;
    logic                             pslverr_sel;
    logic                             timer_clear;
    logic                             timer_run;
    logic                             timer_expired;

    // slot 3 is empty, the decoder answers for it
    assign prdata[3] = '0;
    assign pready[3] = 1'b0;

    axi_lite_front i_front (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .S_AXI_AWADDR, .S_AXI_AWPROT, .S_AXI_AWVALID, .S_AXI_AWREADY,
        .S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WVALID, .S_AXI_WREADY,
        .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
        .S_AXI_ARADDR, .S_AXI_ARPROT, .S_AXI_ARVALID, .S_AXI_ARREADY,
        .S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
        .xfer_ack, .xfer_rsp, .xfer_req, .xfer_cmd
    );

    apb_seq_fsm i_seq (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .xfer_req, .xfer_cmd, .prdata_sel, .pready_sel, .pslverr_sel, .timer_expired,
        .xfer_ack, .xfer_rsp, .psel_en, .penable, .paddr, .pwrite, .pwdata,
        .timer_clear, .timer_run
    );

    apb_wait_timer i_timer (
        .S_AXI_ACLK, .S_AXI_ARESETN, .timer_clear, .timer_run, .timer_expired
    );

    apb_dev_decode i_decode (
        .psel_en, .paddr, .penable, .prdata, .pready,
        .pslverr ('0),
        .psel, .prdata_sel, .pready_sel, .pslverr_sel
    );

    apb_reg_slave #(.WAIT_CYCLES(0)) i_slave0 (
        .S_AXI_ACLK, .S_AXI_ARESETN, .psel (psel[0]), .penable, .paddr, .pwrite, .pwdata,
        .prdata (prdata[0]), .pready (pready[0])
    );

    apb_reg_slave #(.WAIT_CYCLES(3)) i_slave1 (
        .S_AXI_ACLK, .S_AXI_ARESETN, .psel (psel[1]), .penable, .paddr, .pwrite, .pwdata,
        .prdata (prdata[1]), .pready (pready[1])
    );

    // too slow for the timer, every access aborts
    apb_reg_slave #(.WAIT_CYCLES(20)) i_slave2 (
        .S_AXI_ACLK, .S_AXI_ARESETN, .psel (psel[2]), .penable, .paddr, .pwrite, .pwdata,
        .prdata (prdata[2]), .pready (pready[2])
    );

endmodule

`default_nettype wire

/* dv/apb_subsys_props.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_subsys_props (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             psel_en,
    input logic                             penable,
    input logic [bridge_pkg::DEV_COUNT-1:0] psel,
    input logic                             xfer_req,
    input logic                             xfer_ack,
    input logic                             bvalid,
    input logic                             bready,
    input logic [1:0]                       bresp
);

    // exactly one SETUP cycle before ACCESS
    setup_then_access: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(psel_en) |=> psel_en && penable)
        else $error("PENABLE did not follow a single SETUP cycle");

    enable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel_en))
        else $error("PENABLE rose without a SETUP cycle");

    // a slot stays selected for the whole access phase
    enable_with_select: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> $onehot(psel))
        else $error("PENABLE high without exactly one PSEL");

    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(xfer_req) |-> !$past(xfer_ack))
        else $error("xfer_req rose while xfer_ack was high");

    ack_until_req_low: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_ack && xfer_req |=> xfer_ack)
        else $error("xfer_ack dropped while xfer_req was still high");

    b_held: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response not held until BREADY");

endmodule

bind apb_subsys_top apb_subsys_props i_props (
    .clk      (S_AXI_ACLK),
    .rst_n    (S_AXI_ARESETN),
    .psel_en  (psel_en),
    .penable  (penable),
    .psel     (psel),
    .xfer_req (xfer_req),
    .xfer_ack (xfer_ack),
    .bvalid   (S_AXI_BVALID),
    .bready   (S_AXI_BREADY),
    .bresp    (S_AXI_BRESP)
);

`default_nettype wire

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  int                            test_num,
    input  logic                          exp_b,
    input  logic                          exp_r,
    input  logic [1:0]                    exp_resp,
    input  logic [bridge_pkg::DATA_W-1:0] exp_rdata,
    input  logic                          all_sent,
    input  logic                          bvalid,
    input  logic                          bready,
    input  logic [1:0]                    bresp,
    input  logic                          rvalid,
    input  logic                          rready,
    input  logic [1:0]                    rresp,
    input  logic [bridge_pkg::DATA_W-1:0] rdata,
    output int                            tests_done,
    output int                            tests_failed,
    output int                            error_count
);

    int                            cur_test = -1;
    int                            n_done = 0;
    int                            n_failed = 0;
    int                            n_errors = 0;
    logic                          seen_b = 1'b0;
    logic                          seen_r = 1'b0;
    logic                          test_bad = 1'b0;
    logic                          reported = 1'b1;
    logic                          summary_done = 1'b0;
    logic                          b_hold = 1'b0;
    logic                          r_hold = 1'b0;
    logic [1:0]                    bresp_last;
    logic [1:0]                    rresp_last;
    logic [bridge_pkg::DATA_W-1:0] rdata_last;

    assign tests_done   = n_done;
    assign tests_failed = n_failed;
    assign error_count  = n_errors;

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAILED at %0d ns: test %0d %s is %h, expected %h",
                 $time, cur_test, what, got, want);
        n_errors++;
        test_bad = 1'b1;
    endtask

    task automatic report_problem(input string what);
        $display("error at %0d ns in test %0d: %s", $time, cur_test, what);
        n_errors++;
        test_bad = 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (test_num != cur_test) begin
                cur_test = test_num;
                seen_b   = 1'b0;
                seen_r   = 1'b0;
                test_bad = 1'b0;
                reported = 1'b0;
            end
            // a waiting response must hold still
            if (b_hold && (!bvalid || bresp != bresp_last))
                report_problem("BVALID fell or BRESP changed before BREADY");
            if (r_hold && (!rvalid || rresp != rresp_last || rdata != rdata_last))
                report_problem("RVALID fell or the read response changed before RREADY");
            b_hold     = bvalid && !bready;
            r_hold     = rvalid && !rready;
            bresp_last = bresp;
            rresp_last = rresp;
            rdata_last = rdata;

            if (bvalid && bready) begin
                if (!exp_b || seen_b)
                    report_problem("write response that no request asked for");
                else if (bresp !== exp_resp)
                    report_mismatch("BRESP", 32'(bresp), 32'(exp_resp));
                seen_b = 1'b1;
            end
            if (rvalid && rready) begin
                if (!exp_r || seen_r) begin
                    report_problem("read response that no request asked for");
                end else if (exp_b && !seen_b) begin
                    report_problem("read response came before the write response");
                end else begin
                    if (rresp !== exp_resp)
                        report_mismatch("RRESP", 32'(rresp), 32'(exp_resp));
                    if (rdata !== exp_rdata)
                        report_mismatch("RDATA", rdata, exp_rdata);
                end
                seen_r = 1'b1;
            end

            if (!reported && seen_b == exp_b && seen_r == exp_r) begin
                reported = 1'b1;
                n_done++;
                if (test_bad)
                    n_failed++;
                $display("test %0d %s at %0d ns", cur_test, test_bad ? "failed" : "ok", $time);
            end
            if (all_sent && !summary_done) begin
                summary_done = 1'b1;
                $display("%0d tests run, %0d ok, %0d failed, %0d errors",
                         n_done, n_done - n_failed, n_failed, n_errors);
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_both     // write and read presented in the same cycle
    } op_t;

    typedef struct packed {
        op_t                           op;
        logic [bridge_pkg::ADDR_W-1:0] addr;
        logic [bridge_pkg::DATA_W-1:0] wdata;
        logic [bridge_pkg::DATA_W-1:0] exp_rdata;
        logic [1:0]                    exp_resp;
        logic [2:0]                    ready_dly;   // cycles BREADY/RREADY stay low
    } entry_t;

    // worst entry is a timed out access plus ready delay, twice for op_both
    localparam int ENTRY_BUDGET = 2 * (bridge_pkg::TIMEOUT_CYCLES + 8) + 8;

    logic                          clk;
    logic                          rst_n;
    logic [bridge_pkg::ADDR_W-1:0] awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [bridge_pkg::DATA_W-1:0] wdata;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [bridge_pkg::ADDR_W-1:0] araddr;
    logic                          arvalid;
    logic                          arready;
    logic [bridge_pkg::DATA_W-1:0] rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;

    int                            test_num;
    logic                          exp_b;
    logic                          exp_r;
    logic [1:0]                    exp_resp;
    logic [bridge_pkg::DATA_W-1:0] exp_rdata;
    logic                          all_sent;
    int                            tests_done;
    int                            tests_failed;
    int                            error_count;

    entry_t                        tests [$];
    logic [bridge_pkg::DATA_W-1:0] mirror [3][4] = '{default: '0};   // slots 0..2
    integer                        seed;
    int                            cycles = 0;
    int                            cycle_limit;

    tb_clkgen i_clkgen (
        .clk,
        .rst_n
    );

    apb_subsys_top i_dut (
        .S_AXI_ACLK    (clk),
        .S_AXI_ARESETN (rst_n),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWPROT  (3'b000),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WSTRB   (4'hf),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARPROT  (3'b000),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready)
    );

    tb_checker i_checker (
        .clk, .rst_n, .test_num, .exp_b, .exp_r, .exp_resp, .exp_rdata, .all_sent,
        .bvalid, .bready, .bresp, .rvalid, .rready, .rresp, .rdata,
        .tests_done, .tests_failed, .error_count
    );

    // one table entry, the mirror tracks what slots 0 and 1 hold
    function automatic void add_entry(input op_t op, input logic [15:0] addr,
                                      input logic [31:0] data);
        entry_t                e;
        bridge_pkg::apb_addr_u a;
        logic                  kept;
        a.word      = addr;
        kept        = (a.f.dev_idx < 2'd2);   // only slots 0 and 1 store data
        e.op        = op;
        e.addr      = addr;
        e.wdata     = data;
        e.exp_resp  = kept ? bridge_pkg::RESP_OKAY : bridge_pkg::RESP_SLVERR;
        e.exp_rdata = '0;
        if (kept) begin
            if (op != op_read)
                mirror[a.f.dev_idx][a.f.offset[3:2]] = data;
            e.exp_rdata = mirror[a.f.dev_idx][a.f.offset[3:2]];
        end
        e.ready_dly = 3'($random(seed));
        tests.push_back(e);
    endfunction

    task automatic take_response(input logic [2:0] dly);
        @(posedge clk);
        while (!(bvalid || rvalid))
            @(posedge clk);
        repeat (dly) @(posedge clk);
        bready <= bvalid;
        rready <= rvalid;
        @(posedge clk);   // handshake edge
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic run_entry(input int n, input entry_t e);
        logic aw_pend;
        logic w_pend;
        logic ar_pend;
        aw_pend   = (e.op != op_read);
        w_pend    = aw_pend;
        ar_pend   = (e.op != op_write);
        test_num  <= n;
        exp_b     <= aw_pend;
        exp_r     <= ar_pend;
        exp_resp  <= e.exp_resp;
        exp_rdata <= e.exp_rdata;
        awaddr    <= e.addr;
        araddr    <= e.addr;
        wdata     <= e.wdata;
        awvalid   <= aw_pend;
        wvalid    <= w_pend;
        arvalid   <= ar_pend;
        while (aw_pend || w_pend || ar_pend) begin
            @(posedge clk);
            if (aw_pend && awready) begin
                aw_pend = 1'b0;
                awvalid <= 1'b0;
            end
            if (w_pend && wready) begin
                w_pend = 1'b0;
                wvalid <= 1'b0;
            end
            if (ar_pend && arready) begin
                ar_pend = 1'b0;
                arvalid <= 1'b0;
            end
        end
        if (e.op != op_read)
            take_response(e.ready_dly);
        if (e.op != op_write)
            take_response(e.ready_dly);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        test_num  = -1;
        exp_b     = 1'b0;
        exp_r     = 1'b0;
        exp_resp  = '0;
        exp_rdata = '0;
        all_sent  = 1'b0;
        seed      = 32'h044a734d;

        // slot 0, every register written then read back
        for (int r = 0; r < 4; r++)
            add_entry(op_write, 16'(r * 4), {16'h5a00 + 16'(r), 16'hc3c3});
        for (int r = 0; r < 4; r++)
            add_entry(op_read, 16'(r * 4), '0);
        // slot 1 with wait states, mixed with slot 0
        add_entry(op_write, 16'h1000, 32'h0bad_f00d);
        add_entry(op_write, 16'h0004, 32'h1234_5678);
        add_entry(op_write, 16'h1008, 32'hfeed_beef);
        add_entry(op_read,  16'h1000, '0);
        add_entry(op_read,  16'h0004, '0);
        add_entry(op_read,  16'h1008, '0);
        add_entry(op_read,  16'h100c, '0);
        add_entry(op_read,  16'h0000, '0);
        // empty slot
        add_entry(op_write, 16'h3004, 32'hdead_0003);
        add_entry(op_read,  16'h3004, '0);
        // slot 2 always times out
        add_entry(op_write, 16'h2008, 32'hcafe_0002);
        add_entry(op_read,  16'h2008, '0);
        add_entry(op_read,  16'h0008, '0);
        // write and read in one cycle
        add_entry(op_both,  16'h000c, 32'h600d_cafe);
        add_entry(op_both,  16'h1004, 32'h7777_1234);

        cycle_limit = tests.size() * ENTRY_BUDGET + 50;

        @(posedge clk);
        while (rst_n !== 1'b1)
            @(posedge clk);
        @(posedge clk);
        foreach (tests[i])
            run_entry(i, tests[i]);
        all_sent <= 1'b1;
        repeat (2) @(posedge clk);

        if (error_count == 0 && tests_failed == 0 && tests_done == tests.size()) begin
            $display("*** TEST PASSED ***");
        end else begin
            if (tests_done != tests.size())
                $display("only %0d of %0d tests saw all their responses",
                         tests_done, tests.size());
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
design/bridge_pkg.sv
design/apb_wait_timer.sv
design/apb_dev_decode.sv
design/apb_reg_slave.sv
design/apb_seq_fsm.sv
design/axi_lite_front.sv
design/apb_subsys_top.sv
dv/apb_subsys_props.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the AXI4-Lite to APB bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f list.f -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
